/* ldst_unit.f */
core_pkg.sv
ldst_pop.sv
ctrl_cycles.sv
reg_file.sv
core_control.sv
ldst_unit.sv
tb_memory.sv
xfer_checker.sv
tb_ldst_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then judge the run from its log
verilator --binary -j 0 --top-module tb_ldst_unit -f ldst_unit.f -o sim_ldst_unit \
	> build.log 2>&1 \
	&& ./obj_dir/sim_ldst_unit > sim.log 2>&1 \
	|| { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }
grep -q "Simulation finished: FAIL" sim.log && { echo "Testbench reported failure"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "No verdict found in sim.log"; exit 1; }
echo "Testbench passed"

/* tb_ldst_unit.sv */
`timescale 1ns/10ps

module tb_ldst_unit import core_pkg::*;
();

	localparam int mem_words = 1024;
	localparam int insn_count = 400;
	localparam int ack_limit = 500;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic insn_req = 1'b0;
	insn_word insn = '0;
	logic insn_ack, mem_req, mem_ack;
	mem_cmd cmd;
	word rdata;
	int errors, beats;
	logic timed_out = 1'b0;

	always #10 clk = ~clk;

	ldst_unit #(.mem_words(mem_words)) dut (.clk(clk), .reset(reset), .insn_req(insn_req),
		.insn(insn), .mem_ack(mem_ack), .rdata(rdata), .insn_ack(insn_ack), .mem_req(mem_req),
		.cmd(cmd));

	tb_memory #(.mem_words(mem_words)) memory (.clk(clk), .reset(reset), .mem_req(mem_req),
		.cmd(cmd), .mem_ack(mem_ack), .rdata(rdata));

	xfer_checker #(.mem_words(mem_words)) check (.clk(clk), .reset(reset), .insn_req(insn_req),
		.insn(insn), .insn_ack(insn_ack), .mem_req(mem_req), .cmd(cmd), .mem_ack(mem_ack),
		.errors(errors), .beats(beats));

	function automatic insn_word random_insn();
		insn_word i;
		int kind;

		i = insn_word'($urandom);
		kind = $urandom_range(10, 0);
		if (kind < 4) begin
			i.single.fmt_class = 2'b01;
			i.single.imm = 1'b0;
		end else if (kind < 8) begin
			i.multiple.fmt_class = 3'b100;
			if (kind >= 6)
				i.multiple.regs = i.multiple.regs & reg_list'($urandom);  // Sparser lists
		end else if (kind == 8) begin
			i.single.fmt_class = 2'b01;
			i.single.imm = 1'b1;
		end else if (kind == 9) begin
			i.multiple.fmt_class = 3'b100;
			i.multiple.regs = '0;
		end else begin
			i.multiple.fmt_class = 3'b000;
		end
		return i;
	endfunction

	task automatic run_insn(input insn_word i);
		int waited;

		@(posedge clk);
		insn <= i;
		insn_req <= 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!insn_ack && waited < ack_limit);
		insn_req <= 1'b0;
		if (!insn_ack) begin
			$display("Timeout: insn_ack did not rise within %0d cycles", ack_limit);
			timed_out = 1'b1;
		end else begin
			waited = 0;
			while (insn_ack && waited < ack_limit) begin
				@(posedge clk);
				waited++;
			end
			if (insn_ack) begin
				$display("Timeout: insn_ack stayed high after insn_req fell");
				timed_out = 1'b1;
			end
		end
	endtask

	initial begin
		int issued;

		void'($urandom(40760));
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		repeat (4) @(posedge clk);  // Outputs must stay quiet here
		for (issued = 0; issued < insn_count && !timed_out; issued++)
			run_insn(random_insn());
		@(negedge clk);
		$display("Instructions %0d, memory beats %0d, errors %0d, timeouts %0d",
			issued, beats, errors, timed_out);
		if (timed_out || errors != 0)
			$display("Simulation finished: FAIL");
		else
			$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* xfer_checker.sv */
`timescale 1ns/10ps

module xfer_checker import core_pkg::*;
#(
	parameter int mem_words = 1024
)
(
	input  logic     clk,
	input  logic     reset,
	input  logic     insn_req,
	input  insn_word insn,
	input  logic     insn_ack,
	input  logic     mem_req,
	input  mem_cmd   cmd,
	input  logic     mem_ack,
	output int       errors,
	output int       beats
);

	localparam int index_bits = $clog2(mem_words);

	word shadow_regs [0:15];
	word shadow_mem [0:mem_words-1];
	mem_cmd expected [$];
	logic pending, req_q, ack_q;
	logic mem_ack_q;  // Ack as it stood at the edge where a request rises

	initial begin
		for (int a = 0; a < mem_words; a++)
			shadow_mem[index_bits'(a)] = 32'h3c5a_0f96 ^ (word'(a) * 32'h0101_0101);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic void expect_beat(input word byte_addr, input logic load, input reg_num r);
		logic [index_bits-1:0] index;

		index = index_bits'(byte_addr[31:2] % mem_words);
		expected.push_back('{addr: ptr'(index), write: !load, wdata: shadow_regs[r]});
		if (load)
			shadow_regs[r] = shadow_mem[index];
		else
			shadow_mem[index] = shadow_regs[r];
	endfunction

	function automatic void predict_insn(input insn_word i);
		word base, wb, lowest;
		int n, count;
		reg_num r;

		if (i.single.fmt_class == 2'b01 && !i.single.imm) begin
			base = shadow_regs[i.single.rn];
			wb = i.single.increment ? base + word'(i.single.offset) : base - word'(i.single.offset);
			expect_beat(i.single.pre ? wb : base, i.single.load, i.single.rd);
			if ((i.single.writeback || !i.single.pre) && !(i.single.load && i.single.rd == i.single.rn))
				shadow_regs[i.single.rn] = wb;
		end else if (i.multiple.fmt_class == 3'b100 && i.multiple.regs != '0) begin
			base = shadow_regs[i.multiple.rn];
			n = $countones(i.multiple.regs);
			wb = i.multiple.increment ? base + word'(4 * n) : base - word'(4 * n);
			if (i.multiple.increment)
				lowest = i.multiple.pre ? base + 32'd4 : base;
			else
				lowest = i.multiple.pre ? wb : wb + 32'd4;
			count = 0;
			for (int k = 0; k < 16; k++) begin
				r = reg_num'(i.multiple.increment ? k : 15 - k);
				if (i.multiple.regs[r]) begin
					expect_beat(lowest + word'(4 * (i.multiple.increment ? count : n - 1 - count)),
						i.multiple.load, r);
					count++;
				end
			end
			if (i.multiple.writeback && !(i.multiple.load && i.multiple.regs[i.multiple.rn]))
				shadow_regs[i.multiple.rn] = wb;
		end
	endfunction

	function automatic void check_field(input string name, input word want, input word got);
		if (got !== want) begin
			$display("ERROR %0t %s expected %h got %h", $time, name, want, got);
			errors++;
		end
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Comparison
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk) begin
		mem_cmd want;

		if (reset) begin
			for (int r = 0; r < 16; r++)
				shadow_regs[r] = '0;
			expected.delete();
			pending <= 1'b0;
			req_q <= 1'b0;
			ack_q <= 1'b0;
			mem_ack_q <= 1'b0;
			errors = 0;
			beats = 0;
		end else begin
			req_q <= mem_req;
			ack_q <= insn_ack;
			mem_ack_q <= mem_ack;
			if (insn_req && !insn_ack && !pending) begin
				predict_insn(insn);
				pending <= 1'b1;
			end
			if (mem_req && !req_q) begin
				beats++;
				if (mem_ack_q) begin
					$display("%0t: mem_req rose while mem_ack was still high", $time);
					errors++;
				end
				if (!pending || expected.size() == 0) begin
					$display("%0t: memory request that no instruction calls for", $time);
					errors++;
				end else begin
					want = expected.pop_front();
					check_field("cmd.addr", word'(want.addr), word'(cmd.addr));
					check_field("cmd.write", word'(want.write), word'(cmd.write));
					if (want.write)
						check_field("cmd.wdata", want.wdata, cmd.wdata);
				end
			end
			if (insn_ack && !ack_q) begin
				if (!pending) begin
					$display("%0t: insn_ack rose with no instruction pending", $time);
					errors++;
				end else if (expected.size() != 0) begin
					$display("%0t: insn_ack rose with %0d beats missing", $time, expected.size());
					errors++;
				end
				pending <= 1'b0;
			end
		end
	end

endmodule

/* tb_memory.sv */
`timescale 1ns/10ps

module tb_memory import core_pkg::*;
#(
	parameter int mem_words = 1024
)
(
	input  logic   clk,
	input  logic   reset,
	input  logic   mem_req,
	input  mem_cmd cmd,
	output logic   mem_ack,
	output word    rdata
);

	localparam int index_bits = $clog2(mem_words);

	word mem [0:mem_words-1];
	logic ack_q = 1'b0;
	word rdata_q = '0;
	logic busy = 1'b0;
	logic [2:0] wait_left = '0;
	logic [index_bits-1:0] index;

	assign mem_ack = ack_q;
	assign rdata = rdata_q;
	assign index = index_bits'(cmd.addr % mem_words);

	// Each word starts with a value that is unique to its address
	initial begin
		for (int a = 0; a < mem_words; a++)
			mem[index_bits'(a)] = 32'h3c5a_0f96 ^ (word'(a) * 32'h0101_0101);
	end

	always @(posedge clk) begin
		if (reset) begin
			ack_q <= 1'b0;
			busy <= 1'b0;
		end else if (ack_q) begin
			if (!mem_req)
				ack_q <= 1'b0;  // Back to idle once the request has dropped
		end else if (mem_req) begin
			if (!busy) begin
				busy <= 1'b1;
				wait_left <= 3'($urandom_range(5, 0));
			end else if (wait_left != 3'd0) begin
				wait_left <= wait_left - 3'd1;
			end else begin
				busy <= 1'b0;
				ack_q <= 1'b1;
				if (cmd.write)
					mem[index] = cmd.wdata;
				else
					rdata_q <= mem[index];
			end
		end
	end

endmodule

/* ldst_unit.sv */
`timescale 1ns/10ps

module ldst_unit import core_pkg::*;
#(
	parameter int mem_words = 1024
)
(
	input  logic     clk,
	input  logic     reset,
	input  logic     insn_req,
	input  insn_word insn,
	input  logic     mem_ack,
	input  word      rdata,
	output logic     insn_ack,
	output logic     mem_req,
	output mem_cmd   cmd
);

	reg_num ra, rb, wr_reg;
	word rd_value_a, rd_value_b, wr_value;
	logic we;

	core_control #(
		.mem_words(mem_words)
	) control (
		.clk(clk),
		.reset(reset),
		.insn_req(insn_req),
		.insn(insn),
		.mem_ack(mem_ack),
		.rdata(rdata),
		.rd_value_a(rd_value_a),
		.rd_value_b(rd_value_b),
		.insn_ack(insn_ack),
		.mem_req(mem_req),
		.cmd(cmd),
		.ra(ra),
		.rb(rb),
		.we(we),
		.wr_reg(wr_reg),
		.wr_value(wr_value)
	);

	reg_file regs
	(
		.clk(clk),
		.reset(reset),
		.ra(ra),
		.rb(rb),
		.we(we),
		.wr_reg(wr_reg),
		.wr_value(wr_value),
		.rd_value_a(rd_value_a),
		.rd_value_b(rd_value_b)
	);

endmodule

/* core_control.sv */
`timescale 1ns/10ps

module core_control import core_pkg::*;
#(
	parameter int mem_words = 1024
)
(
	input  logic     clk,
	input  logic     reset,
	input  logic     insn_req,
	input  insn_word insn,
	input  logic     mem_ack,
	input  word      rdata,
	input  word      rd_value_a,
	input  word      rd_value_b,
	output logic     insn_ack,
	output logic     mem_req,
	output mem_cmd   cmd,
	output reg_num   ra,
	output reg_num   rb,
	output logic     we,
	output reg_num   wr_reg,
	output word      wr_value
);

	ctrl_cycle cycle, next_cycle;

	logic single_q, pre_q, increment_q, writeback_q, load_q, base_loaded;
	logic [11:0] offset_q;
	reg_num rn_q, xfer_reg;
	reg_list mem_regs;
	ptr addr_q;
	word wb_q;

	logic issue, undefined, is_single, is_multiple;
	logic beat_done, start_beat, pop_valid;
	reg_num pop_lower, pop_upper, popped;
	reg_list next_lower, next_upper;
	word delta, wb_value, first_addr;
	ptr beat_addr;

	assign is_single = insn.single.fmt_class == CLASS_SINGLE && !insn.single.imm;
	assign is_multiple = insn.multiple.fmt_class == CLASS_MULTIPLE && insn.multiple.regs != '0;
	assign undefined = !is_single && !is_multiple;
	assign issue = insn_req && !insn_ack;

	// A new beat waits until the memory has dropped the previous ack
	assign beat_done = mem_req && mem_ack;
	assign start_beat = (cycle == ADDRESS || (cycle == TRANSFER && !mem_req))
		&& !mem_ack && pop_valid;

	ctrl_cycles cycles
	(
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.undefined(undefined),
		.beat_done(beat_done),
		.pop_valid(pop_valid),
		.base_wb(writeback_q),
		.insn_req(insn_req),
		.cycle(cycle),
		.next_cycle(next_cycle)
	);

	ldst_pop pop
	(
		.regs(mem_regs),
		.valid(pop_valid),
		.pop_lower(pop_lower),
		.pop_upper(pop_upper),
		.next_lower(next_lower),
		.next_upper(next_upper)
	);

	// Decrementing modes start from the highest register
	assign popped = increment_q ? pop_lower : pop_upper;
	assign ra = rn_q;
	assign rb = popped;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address arithmetic
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign delta = single_q ? word'(offset_q) : (word'($countones(mem_regs)) << 2);
	assign wb_value = increment_q ? rd_value_a + delta : rd_value_a - delta;

	always_comb begin
		if (single_q)
			first_addr = pre_q ? wb_value : rd_value_a;
		else if (pre_q)
			first_addr = increment_q ? rd_value_a + 32'd4 : rd_value_a - 32'd4;
		else
			first_addr = rd_value_a;
	end

	assign beat_addr = cycle == ADDRESS ? first_addr[31:2] : addr_q;

	// Loads write on the ack edge, the base write fills its own cycle
	assign we = (beat_done && load_q) || (cycle == BASE_WRITEBACK && !base_loaded);
	assign wr_reg = cycle == BASE_WRITEBACK ? rn_q : xfer_reg;
	assign wr_value = cycle == BASE_WRITEBACK ? wb_q : rdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Handshakes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			insn_ack <= 1'b0;
			mem_req <= 1'b0;
			base_loaded <= 1'b0;
		end else begin
			insn_ack <= next_cycle == DONE;

			if (start_beat)
				mem_req <= 1'b1;
			else if (beat_done)
				mem_req <= 1'b0;

			if (cycle == ISSUE && issue)
				base_loaded <= 1'b0;
			else if (beat_done && load_q && xfer_reg == rn_q)
				base_loaded <= 1'b1;  // The loaded value wins over writeback
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Latched instruction and beats
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (cycle == ISSUE && issue) begin
			single_q <= is_single;
			if (is_single) begin
				pre_q <= insn.single.pre;
				increment_q <= insn.single.increment;
				writeback_q <= insn.single.writeback || !insn.single.pre;
				load_q <= insn.single.load;
				rn_q <= insn.single.rn;
				offset_q <= insn.single.offset;
				mem_regs <= reg_list'(1) << insn.single.rd;
			end else begin
				pre_q <= insn.multiple.pre;
				increment_q <= insn.multiple.increment;
				writeback_q <= insn.multiple.writeback;
				load_q <= insn.multiple.load;
				rn_q <= insn.multiple.rn;
				offset_q <= '0;
				mem_regs <= insn.multiple.regs;
			end
		end

		if (cycle == ADDRESS)
			wb_q <= wb_value;  // Taken before any load can touch the base

		if (start_beat) begin
			cmd.addr <= ptr'(beat_addr % mem_words);
			cmd.write <= !load_q;
			cmd.wdata <= rd_value_b;
			xfer_reg <= popped;
			mem_regs <= increment_q ? next_lower : next_upper;
			addr_q <= increment_q ? beat_addr + 30'd1 : beat_addr - 30'd1;
		end else if (cycle == ADDRESS) begin
			addr_q <= first_addr[31:2];
		end
	end

endmodule

/* reg_file.sv */
`timescale 1ns/10ps

module reg_file import core_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  reg_num ra,
	input  reg_num rb,
	input  logic   we,
	input  reg_num wr_reg,
	input  word    wr_value,
	output word    rd_value_a,
	output word    rd_value_b
);

	word regs [0:15];  // R15 is an ordinary register here

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wr_reg] <= wr_value;
		end
	end

	// Reads see the old value during a write cycle
	assign rd_value_a = regs[ra];
	assign rd_value_b = regs[rb];

endmodule

/* ctrl_cycles.sv */
`timescale 1ns/10ps

module ctrl_cycles import core_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      issue,
	input  logic      undefined,
	input  logic      beat_done,
	input  logic      pop_valid,
	input  logic      base_wb,
	input  logic      insn_req,
	output ctrl_cycle cycle,
	output ctrl_cycle next_cycle
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next cycle
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		next_cycle = cycle;

		case (cycle)
			ISSUE:
				if (issue)
					next_cycle = undefined ? DONE : ADDRESS;

			ADDRESS:
				next_cycle = TRANSFER;

			// The popper list already excludes the register of the running beat.
			// A single transfer loads a one-bit list and so makes exactly one beat
			TRANSFER:
				if (beat_done && !pop_valid)
					next_cycle = base_wb ? BASE_WRITEBACK : DONE;

			BASE_WRITEBACK:
				next_cycle = DONE;

			DONE:
				if (!insn_req)
					next_cycle = ISSUE;  // Ack drops on the same edge

			default:
				next_cycle = ISSUE;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// State register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset)
			cycle <= ISSUE;
		else
			cycle <= next_cycle;
	end

endmodule

/* ldst_pop.sv */
`timescale 1ns/10ps

module ldst_pop import core_pkg::*;
(
	input  reg_list regs,
	output logic    valid,
	output reg_num  pop_lower,
	output reg_num  pop_upper,
	output reg_list next_lower,
	output reg_list next_upper
);

	assign valid = |regs;

	// Scan downwards so that the lowest set bit is the last one found
	always_comb begin
		pop_lower = '0;
		for (int i = 15; i >= 0; i--) begin
			if (regs[i])
				pop_lower = reg_num'(i);
		end
	end

	always_comb begin
		pop_upper = '0;
		for (int i = 0; i < 16; i++) begin
			if (regs[i])
				pop_upper = reg_num'(i);
		end
	end

	// An empty list stays empty since bit 0 is already clear
	assign next_lower = regs & ~(reg_list'(1) << pop_lower);
	assign next_upper = regs & ~(reg_list'(1) << pop_upper);

endmodule

/* core_pkg.sv */
package core_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Basic data types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [31:0] word;
	typedef logic [29:0] ptr;  // Word address without byte bits 1:0
	typedef logic [3:0]  reg_num;
	typedef logic [15:0] reg_list;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction formats
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam logic [2:0] CLASS_MULTIPLE = 3'b100;
	localparam logic [1:0] CLASS_SINGLE   = 2'b01;

	// LDM and STM
	typedef struct packed {
		logic [3:0] cond;
		logic [2:0] fmt_class;
		logic       pre;
		logic       increment;
		logic       user_regs;  // S bit, no modes here so it is ignored
		logic       writeback;
		logic       load;
		reg_num     rn;
		reg_list    regs;
	} ldst_multiple_fmt;

	// LDR and STR with an immediate offset
	typedef struct packed {
		logic [3:0]  cond;
		logic [1:0]  fmt_class;
		logic        imm;  // Set means register offset, which is rejected
		logic        pre;
		logic        increment;
		logic        byte_size;
		logic        writeback;
		logic        load;
		reg_num      rn;
		reg_num      rd;
		logic [11:0] offset;
	} ldst_single_fmt;

	typedef union packed {
		ldst_multiple_fmt multiple;
		ldst_single_fmt   single;
	} insn_word;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory port and control cycles
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		ptr   addr;
		logic write;
		word  wdata;
	} mem_cmd;

	typedef enum logic [2:0] {
		ISSUE,
		ADDRESS,
		TRANSFER,
		BASE_WRITEBACK,
		DONE
	} ctrl_cycle;

endpackage
